// ==== verilog/dbg_pkg.sv ====
/*
  Shared definitions of the debug module: DMI widths, register map, field
  positions and state encodings. Only data0, dmcontrol and dmstatus are mapped.
*/
package dbg_pkg;

    // --------------------
    // DMI bus
    // --------------------
    localparam int unsigned DMI_ADDR_W = 7;
    localparam int unsigned DMI_DATA_W = 32;

    localparam logic [DMI_ADDR_W-1:0] ADDR_DATA0     = 7'h04;
    localparam logic [DMI_ADDR_W-1:0] ADDR_DMCONTROL = 7'h10;
    localparam logic [DMI_ADDR_W-1:0] ADDR_DMSTATUS  = 7'h11;

    // --------------------
    // dmcontrol fields
    // --------------------
    localparam int unsigned DMCTL_DMACTIVE_BIT  = 0;
    localparam int unsigned DMCTL_NDMRESET_BIT  = 1;
    localparam int unsigned DMCTL_RESUMEREQ_BIT = 30;
    localparam int unsigned DMCTL_HALTREQ_BIT   = 31;

    // Bits kept in the register; the request bits only fire pulses
    localparam logic [DMI_DATA_W-1:0] DMCTL_STORE_MASK =
        (DMI_DATA_W'(1) << DMCTL_DMACTIVE_BIT) | (DMI_DATA_W'(1) << DMCTL_NDMRESET_BIT);
    localparam logic [DMI_DATA_W-1:0] DMCTL_RUN_MASK =
        (DMI_DATA_W'(1) << DMCTL_HALTREQ_BIT) | (DMI_DATA_W'(1) << DMCTL_RESUMEREQ_BIT);

    // --------------------
    // dmstatus fields
    // --------------------
    localparam logic [3:0]  DMSTATUS_VERSION     = 4'd2;   // Debug spec 0.13
    localparam int unsigned DMSTATUS_HALTED_BIT  = 9;      // allhalted
    localparam int unsigned DMSTATUS_RUNNING_BIT = 11;     // allrunning

    // Decoded register target
    typedef enum logic [1:0] {
        DM_SEL_NONE      = 2'd0,
        DM_SEL_DATA0     = 2'd1,
        DM_SEL_DMCONTROL = 2'd2,
        DM_SEL_DMSTATUS  = 2'd3
    } dm_reg_sel_e;

    // Hart debug state, also used as the command toward the hart
    typedef enum logic [1:0] {
        HART_STATE_RESET  = 2'd0,
        HART_STATE_RUN    = 2'd1,
        HART_STATE_HALTED = 2'd2
    } hart_state_e;

    typedef struct packed {
        logic                                              haltreq;
        logic                                              resumereq;
        logic [DMCTL_RESUMEREQ_BIT-DMCTL_NDMRESET_BIT-2:0] rsvd;
        logic                                              ndmreset;
        logic                                              dmactive;
    } dmcontrol_s;

    // One DMI word, raw or as dmcontrol fields
    typedef union packed {
        logic [DMI_DATA_W-1:0] raw;
        dmcontrol_s            ctl;
    } dm_word_u;

endpackage : dbg_pkg

// ==== verilog/dm_access_if.sv ====
/*
  Decoded register accesses and their read-back. Both valids are single-cycle
  strobes without acknowledge; rd_data is 0 for writes and unmapped reads.
*/
`timescale 1ns/10ps

interface dm_access_if;

    logic                            acc_valid;
    logic                            acc_wr;
    dbg_pkg::dm_reg_sel_e            acc_sel;
    logic [dbg_pkg::DMI_DATA_W-1:0]  acc_wdata;   // Raw view of the DMI word

    logic                            rd_valid;
    logic                            rd_wr;       // Access type, travels with rd_valid
    logic [dbg_pkg::DMI_DATA_W-1:0]  rd_data;

    modport decoder (
        output acc_valid, acc_wr, acc_sel, acc_wdata
    );

    modport regs (
        input  acc_valid, acc_wr, acc_sel, acc_wdata,
        output rd_valid, rd_wr, rd_data
    );

    modport rsp (
        input  rd_valid, rd_wr, rd_data
    );

endinterface : dm_access_if

// ==== verilog/run_ctrl_if.sv ====
/*
  Run control between register file and hart controller. Requests are
  one-cycle pulses; a pulse seen while busy is high gets dropped.
*/
`timescale 1ns/10ps

interface run_ctrl_if;

    logic                  halt_req;
    logic                  resume_req;
    logic                  busy;         // Command outstanding at the hart
    dbg_pkg::hart_state_e  hart_state;   // Already qualified

    modport regs (
        output halt_req, resume_req,
        input  busy, hart_state
    );

    modport ctrl (
        input  halt_req, resume_req,
        output busy, hart_state
    );

endinterface : run_ctrl_if

// ==== verilog/dmi_req_decoder.sv ====
/*
  DMI input stage. One register stage, no back-pressure: a request on every
  cycle is accepted. Unmapped addresses decode to DM_SEL_NONE.
*/
`timescale 1ns/10ps

module dmi_req_decoder (
    input  logic                            clk,
    input  logic                            dm_rst_n,
    input  logic                            dmi_req_i,
    input  logic                            dmi_wr_i,
    input  logic [dbg_pkg::DMI_ADDR_W-1:0]  dmi_addr_i,
    input  logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_wdata_i,
    dm_access_if.decoder                    acc
);

    dbg_pkg::dm_reg_sel_e  sel_d;
    logic                  acc_valid_q;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        case (dmi_addr_i)
            dbg_pkg::ADDR_DATA0:     sel_d = dbg_pkg::DM_SEL_DATA0;
            dbg_pkg::ADDR_DMCONTROL: sel_d = dbg_pkg::DM_SEL_DMCONTROL;
            dbg_pkg::ADDR_DMSTATUS:  sel_d = dbg_pkg::DM_SEL_DMSTATUS;
            default:                 sel_d = dbg_pkg::DM_SEL_NONE;
        endcase
    end

    // Strobe
    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            acc_valid_q <= 1'b0;
        end else begin
            acc_valid_q <= dmi_req_i;
        end
    end

    // Access payload, only meaningful with the strobe
    always_ff @(posedge clk) begin
        if (dmi_req_i) begin
            acc.acc_wr    <= dmi_wr_i;
            acc.acc_sel   <= sel_d;
            acc.acc_wdata <= dmi_wdata_i;
        end
    end

    assign acc.acc_valid = acc_valid_q;

endmodule : dmi_req_decoder

// ==== verilog/dm_regs.sv ====
/*
  Register file: data0, dmcontrol (dmactive and ndmreset only) and dmstatus.
  haltreq and resumereq only pulse run control and always read back as 0.
  Halt and resume need dmactive set in the same write.
*/
`timescale 1ns/10ps

module dm_regs (
    input  logic        clk,
    input  logic        dm_rst_n,
    dm_access_if.regs   acc,
    run_ctrl_if.regs    rc,
    output logic        ndm_rst_n_o
);

    logic [dbg_pkg::DMI_DATA_W-1:0]  data0_q;
    dbg_pkg::dm_word_u               dmctl_q;
    dbg_pkg::dm_word_u               wr_word;
    logic [dbg_pkg::DMI_DATA_W-1:0]  dmstatus_word;
    logic [dbg_pkg::DMI_DATA_W-1:0]  rd_word;
    logic                            wr_en;
    logic                            dmctl_wr;
    logic                            run_wr;
    logic                            halt_req_q;
    logic                            resume_req_q;
    logic                            rd_valid_q;

    assign wr_word.raw = acc.acc_wdata;
    assign wr_en       = acc.acc_valid & acc.acc_wr;
    assign dmctl_wr    = wr_en & (acc.acc_sel == dbg_pkg::DM_SEL_DMCONTROL);

    // Run request only with dmactive set and no command outstanding
    assign run_wr = dmctl_wr & wr_word.ctl.dmactive & ~rc.busy
                  & (|(wr_word.raw & dbg_pkg::DMCTL_RUN_MASK));

    // --------------------
    // Register writes
    // --------------------
    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            data0_q     <= '0;
            dmctl_q.raw <= '0;
        end else if (wr_en) begin
            if (acc.acc_sel == dbg_pkg::DM_SEL_DATA0) begin
                data0_q <= acc.acc_wdata;
            end
            if (dmctl_wr) begin
                dmctl_q.raw <= acc.acc_wdata & dbg_pkg::DMCTL_STORE_MASK;
            end
        end
    end

    // Halt wins over resume when both are set
    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            halt_req_q   <= 1'b0;
            resume_req_q <= 1'b0;
        end else begin
            halt_req_q   <= run_wr & wr_word.ctl.haltreq;
            resume_req_q <= run_wr & wr_word.ctl.resumereq & ~wr_word.ctl.haltreq;
        end
    end

    // --------------------
    // Read-back
    // --------------------
    always_comb begin
        dmstatus_word = '0;
        dmstatus_word[$bits(dbg_pkg::DMSTATUS_VERSION)-1:0] = dbg_pkg::DMSTATUS_VERSION;
        dmstatus_word[dbg_pkg::DMSTATUS_HALTED_BIT]  = (rc.hart_state == dbg_pkg::HART_STATE_HALTED);
        dmstatus_word[dbg_pkg::DMSTATUS_RUNNING_BIT] = (rc.hart_state == dbg_pkg::HART_STATE_RUN);
    end

    always_comb begin
        case (acc.acc_sel)
            dbg_pkg::DM_SEL_DATA0:     rd_word = data0_q;
            dbg_pkg::DM_SEL_DMCONTROL: rd_word = dmctl_q.raw;
            dbg_pkg::DM_SEL_DMSTATUS:  rd_word = dmstatus_word;
            default:                   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= acc.acc_valid;   // Every access answers
        end
    end

    always_ff @(posedge clk) begin
        if (acc.acc_valid) begin
            acc.rd_wr   <= acc.acc_wr;
            acc.rd_data <= acc.acc_wr ? '0 : rd_word;
        end
    end

    assign acc.rd_valid  = rd_valid_q;
    assign rc.halt_req   = halt_req_q;
    assign rc.resume_req = resume_req_q;
    assign ndm_rst_n_o   = ~dmctl_q.ctl.ndmreset;

endmodule : dm_regs

// ==== verilog/hart_run_ctrl.sv ====
/*
  Hart run control. Holds the command request until a response is seen with
  the RDC qualifier high; while it is low the hart reports as in reset.
*/
`timescale 1ns/10ps

module hart_run_ctrl (
    input  logic                  clk,
    input  logic                  dm_rst_n,
    input  logic                  hart_cmd_resp_i,
    input  dbg_pkg::hart_state_e  hart_dbg_state_i,
    input  logic                  hart_rdc_qlfy_i,
    output logic                  hart_cmd_req_o,
    output dbg_pkg::hart_state_e  hart_cmd_o,
    run_ctrl_if.ctrl              rc
);

    logic                  cmd_req_q;
    dbg_pkg::hart_state_e  cmd_q;
    logic                  cmd_resp_qlfy;
    logic                  cmd_start;

    // --------------------
    // Input qualification
    // --------------------
    assign cmd_resp_qlfy = hart_cmd_resp_i & hart_rdc_qlfy_i;

    assign rc.hart_state = hart_rdc_qlfy_i ? hart_dbg_state_i
                                           : dbg_pkg::HART_STATE_RESET;

    // New pulses are only taken while idle
    assign cmd_start = ~cmd_req_q & (rc.halt_req | rc.resume_req);

    // --------------------
    // Command register
    // --------------------
    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            cmd_req_q <= 1'b0;
            cmd_q     <= dbg_pkg::HART_STATE_RESET;
        end else if (cmd_start) begin
            cmd_req_q <= 1'b1;
            if (rc.halt_req) begin
                cmd_q <= dbg_pkg::HART_STATE_HALTED;
            end else begin
                cmd_q <= dbg_pkg::HART_STATE_RUN;
            end
        end else if (cmd_req_q & cmd_resp_qlfy) begin
            cmd_req_q <= 1'b0;                        // Hart acknowledged
            cmd_q     <= dbg_pkg::HART_STATE_RESET;
        end
    end

    assign hart_cmd_req_o = cmd_req_q;
    assign hart_cmd_o     = cmd_q;
    assign rc.busy        = cmd_req_q;   // Whole request span

endmodule : hart_run_ctrl

// ==== verilog/dmi_rsp_buffer.sv ====
/*
  DMI output stage. Response pulse one cycle after rd_valid; read data is
  held until the next read response, writes leave it untouched.
*/
`timescale 1ns/10ps

module dmi_rsp_buffer (
    input  logic                            clk,
    input  logic                            dm_rst_n,
    dm_access_if.rsp                        acc,
    output logic                            dmi_resp_o,
    output logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_rdata_o
);

    logic                            resp_q;
    logic [dbg_pkg::DMI_DATA_W-1:0]  rdata_q;
    logic                            rdata_upd;

    assign rdata_upd = acc.rd_valid & ~acc.rd_wr;   // Reads only

    always_ff @(posedge clk, negedge dm_rst_n) begin
        if (~dm_rst_n) begin
            resp_q  <= 1'b0;
            rdata_q <= '0;
        end else begin
            resp_q <= acc.rd_valid;
            if (rdata_upd) begin
                rdata_q <= acc.rd_data;
            end
        end
    end

    assign dmi_resp_o  = resp_q;
    assign dmi_rdata_o = rdata_q;

endmodule : dmi_rsp_buffer

// ==== verilog/dbg_core_top.sv ====
/*
  Debug module reached through its DMI port. Two requests may be in flight;
  the response follows two cycles after the request. The hart is external.
*/
`timescale 1ns/10ps

module dbg_core_top (
    input  logic                            clk,
    input  logic                            dm_rst_n,

    // DMI
    input  logic                            dmi_req_i,
    input  logic                            dmi_wr_i,
    input  logic [dbg_pkg::DMI_ADDR_W-1:0]  dmi_addr_i,
    input  logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_wdata_i,
    output logic                            dmi_resp_o,
    output logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_rdata_o,

    // Hart run control
    output logic                            hart_cmd_req_o,
    output dbg_pkg::hart_state_e            hart_cmd_o,
    input  logic                            hart_cmd_resp_i,
    input  dbg_pkg::hart_state_e            hart_dbg_state_i,
    input  logic                            hart_rdc_qlfy_i,

    output logic                            ndm_rst_n_o       // Non-debug reset
);

    dm_access_if acc_if ();
    run_ctrl_if  rc_if ();

    // --------------------
    // Access path
    // --------------------
    dmi_req_decoder decoder_inst (
        .clk         (clk         ),
        .dm_rst_n    (dm_rst_n    ),
        .dmi_req_i   (dmi_req_i   ),
        .dmi_wr_i    (dmi_wr_i    ),
        .dmi_addr_i  (dmi_addr_i  ),
        .dmi_wdata_i (dmi_wdata_i ),
        .acc         (acc_if      )
    );

    dm_regs regs_inst (
        .clk         (clk         ),
        .dm_rst_n    (dm_rst_n    ),
        .acc         (acc_if      ),
        .rc          (rc_if       ),
        .ndm_rst_n_o (ndm_rst_n_o )
    );

    dmi_rsp_buffer rsp_inst (
        .clk         (clk         ),
        .dm_rst_n    (dm_rst_n    ),
        .acc         (acc_if      ),
        .dmi_resp_o  (dmi_resp_o  ),
        .dmi_rdata_o (dmi_rdata_o )
    );

    // Hart side
    hart_run_ctrl run_ctrl_inst (
        .clk              (clk              ),
        .dm_rst_n         (dm_rst_n         ),
        .hart_cmd_resp_i  (hart_cmd_resp_i  ),
        .hart_dbg_state_i (hart_dbg_state_i ),
        .hart_rdc_qlfy_i  (hart_rdc_qlfy_i  ),
        .hart_cmd_req_o   (hart_cmd_req_o   ),
        .hart_cmd_o       (hart_cmd_o       ),
        .rc               (rc_if            )
    );

endmodule : dbg_core_top

// ==== verification/dbg_core_properties.sv ====
/*
  Concurrent checks on the ports of dbg_core_top, attached by bind.
  Failures are counted in assert_errors as well as reported.
*/
`timescale 1ns/10ps

module dbg_core_properties (
    input logic                            clk,
    input logic                            dm_rst_n,
    input logic                            dmi_req_i,
    input logic                            dmi_resp_o,
    input logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_rdata_o,
    input logic                            hart_cmd_req_o,
    input logic                            hart_cmd_resp_i,
    input logic                            hart_rdc_qlfy_i,
    input logic                            ndm_rst_n_o
);

    int assert_errors = 0;   // Read by the testbench

    // Response follows the request by two cycles
    resp_pair_a: assert property (@(posedge clk) disable iff (!dm_rst_n)
        (dmi_resp_o && $past(dmi_resp_o)) |-> ($past(dmi_req_i, 3) && $past(dmi_req_i, 4)))
    else begin
        assert_errors++;
        $error("dmi_resp_o high on two cycles without two consecutive requests");
    end

    cmd_hold_a: assert property (@(posedge clk) disable iff (!dm_rst_n)
        (hart_cmd_req_o && !(hart_cmd_resp_i && hart_rdc_qlfy_i)) |=> hart_cmd_req_o)
    else begin
        assert_errors++;
        $error("hart_cmd_req_o dropped without a qualified response");
    end

    rdata_hold_a: assert property (@(posedge clk) disable iff (!dm_rst_n)
        !dmi_resp_o |-> $stable(dmi_rdata_o))
    else begin
        assert_errors++;
        $error("dmi_rdata_o changed without a response");
    end

    // First edge out of reset
    reset_out_a: assert property (@(posedge clk)
        $rose(dm_rst_n) |-> (!dmi_resp_o && !hart_cmd_req_o && dmi_rdata_o == '0 && ndm_rst_n_o))
    else begin
        assert_errors++;
        $error("outputs not inactive after reset");
    end

endmodule : dbg_core_properties

// ==== verification/tb_dbg_core_top.sv ====
/*
  Testbench for dbg_core_top, run from the project root. Operations and expected
  values come from verification/dbg_tests.txt. The hart model acks after 1 to 8 cycles.
*/
`timescale 1ns/10ps

module tb_dbg_core_top;

    localparam int DRV_DELAY    = 2;    // ns after the rising edge
    localparam int RESP_TIMEOUT = 8;    // cycles
    localparam int POLL_LIMIT   = 40;   // reads
    localparam int SETTLE_CYC   = 12;   // longer than the slowest hart ack

    logic                            clk;
    logic                            dm_rst_n;
    logic                            dmi_req_i;
    logic                            dmi_wr_i;
    logic [dbg_pkg::DMI_ADDR_W-1:0]  dmi_addr_i;
    logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_wdata_i;
    logic                            dmi_resp_o;
    logic [dbg_pkg::DMI_DATA_W-1:0]  dmi_rdata_o;
    logic                            hart_cmd_req_o;
    dbg_pkg::hart_state_e            hart_cmd_o;
    logic                            hart_cmd_resp_i;
    dbg_pkg::hart_state_e            hart_dbg_state_i;
    logic                            hart_rdc_qlfy_i;
    logic                            ndm_rst_n_o;

    integer                          seed;
    int unsigned                     ack_delay;
    int                              err_count;
    int                              test_count;
    int                              fail_tests;
    logic [dbg_pkg::DMI_DATA_W-1:0]  last_rdata;   // Expected hold value of dmi_rdata_o

    dbg_core_top dbg_core_top_inst (.*);

    bind dbg_core_top dbg_core_properties props_inst (
        .clk             (clk             ),
        .dm_rst_n        (dm_rst_n        ),
        .dmi_req_i       (dmi_req_i       ),
        .dmi_resp_o      (dmi_resp_o      ),
        .dmi_rdata_o     (dmi_rdata_o     ),
        .hart_cmd_req_o  (hart_cmd_req_o  ),
        .hart_cmd_resp_i (hart_cmd_resp_i ),
        .hart_rdc_qlfy_i (hart_rdc_qlfy_i ),
        .ndm_rst_n_o     (ndm_rst_n_o     )
    );

    always #20 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #DRV_DELAY;
    endtask

    // --------------------
    // Hart model
    // --------------------
    always begin
        next_cycle();
        if (dm_rst_n && hart_cmd_req_o && !hart_cmd_resp_i) begin
            ack_delay = 32'd1 + ($unsigned($random(seed)) % 32'd8);
            repeat (ack_delay - 1) next_cycle();
            hart_dbg_state_i = hart_cmd_o;   // Hart moves to the commanded state
            hart_cmd_resp_i  = 1'b1;
            next_cycle();
            hart_cmd_resp_i  = 1'b0;
        end
    end

    // One DMI access, entered a drive delay after an edge
    task automatic dmi_access(input logic wr, input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
                              input logic [dbg_pkg::DMI_DATA_W-1:0] wdata,
                              output logic [dbg_pkg::DMI_DATA_W-1:0] rdata);
        int cycles;
        cycles      = 0;
        dmi_req_i   = 1'b1;
        dmi_wr_i    = wr;
        dmi_addr_i  = addr;
        dmi_wdata_i = wdata;
        next_cycle();
        dmi_req_i = 1'b0;
        while (!dmi_resp_o && cycles < RESP_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        rdata = dmi_rdata_o;
        if (!dmi_resp_o) begin
            $display("No response on dmi_resp_o within %0d cycles", RESP_TIMEOUT);
            err_count++;
        end else begin
            if (cycles != 2) begin
                $display("[FAIL] dmi_resp_o latency: got 0x%0h, expected 0x2", cycles);
                err_count++;
            end
            next_cycle();
            if (dmi_resp_o) begin
                $display("dmi_resp_o stayed high for more than one cycle");
                err_count++;
            end
        end
    endtask

    // --------------------
    // Stimulus from file
    // --------------------
    initial begin
        string                           line;
        logic [7:0]                      op;
        logic [dbg_pkg::DMI_ADDR_W-1:0]  addr;
        logic [dbg_pkg::DMI_DATA_W-1:0]  wdata;
        logic [dbg_pkg::DMI_DATA_W-1:0]  exp_val;
        logic [dbg_pkg::DMI_DATA_W-1:0]  rdata;
        int                              fd;
        int                              n;
        int                              polls;
        int                              waits;
        int                              errs_before;
        clk              = 1'b0;
        dm_rst_n         = 1'b0;
        dmi_req_i        = 1'b0;
        dmi_wr_i         = 1'b0;
        dmi_addr_i       = '0;
        dmi_wdata_i      = '0;
        hart_cmd_resp_i  = 1'b0;
        hart_dbg_state_i = dbg_pkg::HART_STATE_RUN;   // Hart runs out of reset
        hart_rdc_qlfy_i  = 1'b1;
        seed             = 26;
        err_count        = 0;
        test_count       = 0;
        fail_tests       = 0;
        last_rdata       = '0;
        repeat (3) @(posedge clk);
        #DRV_DELAY;
        dm_rst_n = 1'b1;

        fd = $fopen("verification/dbg_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/dbg_tests.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h", op, addr, wdata, exp_val);
                    if (n == 4) begin
                        errs_before = err_count;
                        test_count++;
                        case (op)
                            "W": begin
                                dmi_access(1'b1, addr, wdata, rdata);
                                if (dmi_rdata_o !== last_rdata) begin
                                    $display("[FAIL] dmi_rdata_o: got 0x%08h, expected 0x%08h",
                                             dmi_rdata_o, last_rdata);
                                    err_count++;
                                end
                                if (ndm_rst_n_o !== exp_val[0]) begin
                                    $display("[FAIL] ndm_rst_n_o: got 0x%0h, expected 0x%0h",
                                             ndm_rst_n_o, exp_val[0]);
                                    err_count++;
                                end
                            end
                            "R": begin
                                dmi_access(1'b0, addr, '0, rdata);
                                if (rdata !== exp_val) begin
                                    $display("[FAIL] dmi_rdata_o: got 0x%08h, expected 0x%08h",
                                             rdata, exp_val);
                                    err_count++;
                                end
                                last_rdata = exp_val;
                            end
                            "P": begin
                                polls = 0;
                                rdata = ~exp_val;
                                while (rdata !== exp_val && polls < POLL_LIMIT) begin
                                    dmi_access(1'b0, addr, '0, rdata);
                                    polls++;
                                end
                                if (rdata !== exp_val) begin
                                    $display("Poll of 0x%02h never returned 0x%08h in %0d reads",
                                             addr, exp_val, POLL_LIMIT);
                                    err_count++;
                                end
                                last_rdata = exp_val;
                                // Command done before the next request
                                waits = 0;
                                while (hart_cmd_req_o && waits < SETTLE_CYC) begin
                                    next_cycle();
                                    waits++;
                                end
                                if (hart_cmd_req_o) begin
                                    $display("hart_cmd_req_o still high %0d cycles after the poll",
                                             SETTLE_CYC);
                                    err_count++;
                                end
                            end
                            "Q": begin
                                repeat (SETTLE_CYC) next_cycle();
                                if (hart_cmd_req_o !== exp_val[0]) begin
                                    $display("[FAIL] hart_cmd_req_o: got 0x%0h, expected 0x%0h",
                                             hart_cmd_req_o, exp_val[0]);
                                    err_count++;
                                end
                                hart_rdc_qlfy_i = wdata[0];
                            end
                            default: begin
                                $display("Unknown operation %s in the test file", op);
                                err_count++;
                            end
                        endcase
                        if (err_count != errs_before) begin
                            fail_tests++;
                        end
                        $display("Test %0d: %s 0x%02h 0x%08h -> %s", test_count, op, addr,
                                 wdata, (err_count == errs_before) ? "ok" : "wrong");
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 test_count, test_count - fail_tests, fail_tests,
                 dbg_core_top_inst.props_inst.assert_errors);
        if (err_count == 0 && test_count > 0
            && dbg_core_top_inst.props_inst.assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_dbg_core_top

// ==== verification/dbg_tests.txt ====
# op addr wdata expected (hex); op W write, R read, P poll until read equals expected, Q qualifier
# W expected: ndm_rst_n_o after the write; Q: wdata is the new level, expected is hart_cmd_req_o
R 04 00000000 00000000
W 04 a5a55a5a 00000001
R 04 00000000 a5a55a5a
W 04 13572468 00000001
R 04 00000000 13572468
R 7f 00000000 00000000
W 20 ffffffff 00000001
R 04 00000000 13572468
R 10 00000000 00000000
R 11 00000000 00000802
W 10 80000001 00000001
P 11 00000000 00000202
R 10 00000000 00000001
W 10 40000001 00000001
P 11 00000000 00000802
R 10 00000000 00000001
W 10 00000003 00000000
R 10 00000000 00000003
W 10 00000001 00000001
R 10 00000000 00000001
Q 00 00000000 00000000
R 11 00000000 00000002
W 10 80000001 00000001
Q 00 00000001 00000001
P 11 00000000 00000202
W 10 40000001 00000001
P 11 00000000 00000802
W 10 00000000 00000001
R 10 00000000 00000000

// ==== list.f ====
verilog/dbg_pkg.sv
verilog/dm_access_if.sv
verilog/run_ctrl_if.sv
verilog/dmi_req_decoder.sv
verilog/dm_regs.sv
verilog/hart_run_ctrl.sv
verilog/dmi_rsp_buffer.sv
verilog/dbg_core_top.sv
verification/dbg_core_properties.sv
verification/tb_dbg_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run from the project root; the log is searched for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_dbg_core_top -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^TEST RESULT: PASS$" sim.log 2> /dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
